// ==== src/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    // Audio RAM geometry
    localparam int CHANNELS = 8;
    localparam int FRAMES   = 256;
    localparam int CHAN_W   = $clog2(CHANNELS);
    localparam int FRAME_W  = $clog2(FRAMES);
    // Channel in the upper bits, frame in the lower
    localparam int AUDIO_W  = CHAN_W + FRAME_W;

    // Program memory, two banks of CODE words
    localparam int CODE   = 256;
    localparam int CODE_W = $clog2(CODE);
    localparam int COEF_W = CODE_W + 1;

    // Bus regions, compared with adr[31:24]
    localparam logic [7:0] REGION_COEF   = 8'h60;
    localparam logic [7:0] REGION_RESULT = 8'h61;
    localparam logic [7:0] REGION_STATUS = 8'h62;
    localparam logic [7:0] REGION_INPUT  = 8'h64;

    // Word indices inside the status region
    localparam logic [1:0] REG_CONTROL = 2'd0;
    localparam logic [1:0] REG_STATUS  = 2'd1;
    localparam logic [1:0] REG_CAPTURE = 2'd2;
    localparam logic [1:0] REG_EOC     = 2'd3;

endpackage

`default_nettype wire

// ==== src/seq_pkg.sv ====
`default_nettype none

package seq_pkg;

    // Sequencer opcodes, unlisted codes behave as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_MAC  = 4'h1,
        OP_MACZ = 4'h2,
        OP_SAVE = 4'h3,
        OP_HALT = 4'hf
    } opcode_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } seq_state_t;

    // Instruction word layout, bit 24 is spare
    localparam int OP_HI     = 31;
    localparam int OP_LO     = 28;
    localparam int CHAN_HI   = 27;
    localparam int CHAN_LO   = 25;
    localparam int OFFSET_HI = 23;
    localparam int OFFSET_LO = 16;
    localparam int GAIN_HI   = 15;
    localparam int GAIN_LO   = 0;

    localparam int ACC_W = 40;

    // Execute, accumulate and result write stages behind decode
    localparam int DRAIN_CYCLES = 3;

endpackage

`default_nettype wire

// ==== src/dpram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dpram #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 256
) (
    input  wire                       ck,
    input  wire                       we,
    input  wire [$clog2(DEPTH)-1:0]   waddr,
    input  wire [WIDTH-1:0]           wdata,
    input  wire [$clog2(DEPTH)-1:0]   raddr,
    output logic [WIDTH-1:0]          rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Read returns old data on a same-address collision
    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== src/host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_regs (
    input  wire                            ck,
    input  wire                            rst,
    input  wire                            cyc,
    input  wire                            we,
    input  wire [31:0]                     adr,
    input  wire [31:0]                     dat,
    input  wire                            done,
    input  wire                            error,
    input  wire [31:0]                     capture,
    input  wire [15:0]                     result_rdata,
    output logic                           ack,
    output logic [31:0]                    rdt,
    output logic                           coef_we,
    output logic [audio_pkg::COEF_W-1:0]   coef_waddr,
    output logic                           audio_we,
    output logic [audio_pkg::AUDIO_W-1:0]  audio_waddr,
    output logic [audio_pkg::FRAME_W-1:0]  frame,
    output logic                           bank,
    output logic                           start,
    output logic [audio_pkg::CHAN_W-1:0]   result_raddr
);

    logic [7:0] region;
    logic [1:0] reg_idx;
    logic       in_coef;
    logic       in_result;
    logic       in_status;
    logic       in_input;
    logic       first;
    logic       ctl_we;
    logic       eoc;
    logic       eoc_q;
    logic       running;
    logic       done_q;
    logic       status_done;
    logic       status_error;

    assign region  = adr[31:24];
    assign reg_idx = adr[3:2];

    assign in_coef   = (region == audio_pkg::REGION_COEF);
    assign in_result = (region == audio_pkg::REGION_RESULT);
    assign in_status = (region == audio_pkg::REGION_STATUS);
    assign in_input  = (region == audio_pkg::REGION_INPUT);

    // First cycle of an access, ack follows on the next edge
    assign first = cyc && !ack && (in_coef || in_result || in_status || in_input);

    // Host loads the bank the sequencer is not using
    assign coef_we      = first && we && in_coef;
    assign coef_waddr   = {~bank, adr[audio_pkg::CODE_W+1:2]};
    assign audio_we     = first && we && in_input;
    assign audio_waddr  = adr[audio_pkg::AUDIO_W+1:2];
    assign result_raddr = adr[audio_pkg::CHAN_W+1:2];

    assign ctl_we = first && we && in_status && (reg_idx == audio_pkg::REG_CONTROL);
    assign eoc    = first && we && in_status && (reg_idx == audio_pkg::REG_EOC) && !running;

    // Stale flags from the last run stay hidden while a run is pending
    assign status_done  = done && !running;
    assign status_error = error && !running;

    always_comb begin
        rdt = 32'h0;
        if (in_result) begin
            rdt = {16'h0, result_rdata};
        end else if (in_status) begin
            case (reg_idx)
                audio_pkg::REG_CONTROL: rdt = {23'h0, frame, 1'b0};
                audio_pkg::REG_STATUS:  rdt = {29'h0, bank, status_error, status_done};
                audio_pkg::REG_CAPTURE: rdt = capture;
                default:                rdt = 32'h0;
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (ctl_we) begin
            frame <= dat[audio_pkg::FRAME_W:1];
        end
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            ack     <= 1'b0;
            eoc_q   <= 1'b0;
            start   <= 1'b0;
            bank    <= 1'b0;
            running <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            ack    <= first;
            eoc_q  <= eoc;
            start  <= eoc_q;
            done_q <= done;
            // Bank swaps in the ack cycle, start goes out one cycle later
            if (eoc) begin
                bank    <= ~bank;
                running <= 1'b1;
            end else if (done && !done_q) begin
                running <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/seq_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_decode (
    input  wire                            ck,
    input  wire                            rst,
    input  wire                            start,
    input  wire                            bank,
    input  wire [audio_pkg::FRAME_W-1:0]   frame,
    input  wire [31:0]                     coef_rdata,
    output logic [audio_pkg::COEF_W-1:0]   coef_raddr,
    output logic [audio_pkg::AUDIO_W-1:0]  audio_raddr,
    output logic                           op_valid,
    output seq_pkg::opcode_t               op,
    output logic [audio_pkg::CHAN_W-1:0]   chan,
    output logic signed [15:0]             gain,
    output logic                           done,
    output logic                           error
);

    seq_pkg::seq_state_t            state;
    // Extra top bit flags a run past the last address
    logic [audio_pkg::CODE_W:0]     pc;
    logic                           fetch_q;
    logic                           halt_now;
    logic [1:0]                     drain_cnt;
    seq_pkg::opcode_t               fetch_op;
    logic [audio_pkg::FRAME_W-1:0]  tap;

    assign fetch_op   = seq_pkg::opcode_t'(coef_rdata[seq_pkg::OP_HI:seq_pkg::OP_LO]);
    assign halt_now   = fetch_q && (fetch_op == seq_pkg::OP_HALT);
    assign coef_raddr = {bank, pc[audio_pkg::CODE_W-1:0]};

    // Past samples, wraps modulo the frame count
    assign tap = frame - coef_rdata[seq_pkg::OFFSET_HI:seq_pkg::OFFSET_LO];

    always_ff @(posedge ck) begin
        if (rst) begin
            state     <= seq_pkg::IDLE;
            pc        <= '0;
            fetch_q   <= 1'b0;
            drain_cnt <= '0;
            done      <= 1'b0;
            error     <= 1'b0;
        end else begin
            fetch_q <= (state == seq_pkg::RUN) && !pc[audio_pkg::CODE_W] && !halt_now;
            case (state)
                seq_pkg::IDLE, seq_pkg::DONE: begin
                    if (start) begin
                        state <= seq_pkg::RUN;
                        pc    <= '0;
                        done  <= 1'b0;
                        error <= 1'b0;
                    end
                end
                seq_pkg::RUN: begin
                    // Overrun is only an error if word 255 was not a HALT
                    if (halt_now || pc[audio_pkg::CODE_W]) begin
                        state     <= seq_pkg::DRAIN;
                        drain_cnt <= '0;
                        error     <= !halt_now;
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
                seq_pkg::DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == 2'(seq_pkg::DRAIN_CYCLES - 1)) begin
                        state <= seq_pkg::DONE;
                        done  <= 1'b1;
                    end
                end
                default: state <= seq_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= fetch_q && !halt_now;
        end
    end

    // Decoded fields travel with the audio read address
    always_ff @(posedge ck) begin
        op          <= fetch_q ? fetch_op : seq_pkg::OP_NOP;
        chan        <= coef_rdata[seq_pkg::CHAN_HI:seq_pkg::CHAN_LO];
        gain        <= $signed(coef_rdata[seq_pkg::GAIN_HI:seq_pkg::GAIN_LO]);
        audio_raddr <= {coef_rdata[seq_pkg::CHAN_HI:seq_pkg::CHAN_LO], tap};
    end

endmodule

`default_nettype wire

// ==== src/seq_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_execute (
    input  wire                                ck,
    input  wire                                rst,
    input  wire                                op_valid,
    input  seq_pkg::opcode_t                   op,
    input  wire [audio_pkg::CHAN_W-1:0]        chan,
    input  wire signed [15:0]                  gain,
    input  wire [15:0]                         audio_rdata,
    output logic signed [seq_pkg::ACC_W-1:0]   acc,
    output logic                               save_valid,
    output logic [audio_pkg::CHAN_W-1:0]       save_chan
);

    logic                               ex_valid;
    seq_pkg::opcode_t                   ex_op;
    logic [audio_pkg::CHAN_W-1:0]       ex_chan;
    logic signed [15:0]                 ex_gain;
    logic signed [31:0]                 product;
    logic signed [seq_pkg::ACC_W-1:0]   product_ext;

    // Sample arrives from the audio RAM in the same cycle as ex_op
    assign product     = ex_gain * $signed(audio_rdata);
    assign product_ext = product;

    always_ff @(posedge ck) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= op_valid;
        end
    end

    always_ff @(posedge ck) begin
        ex_op   <= op;
        ex_chan <= chan;
        ex_gain <= gain;
    end

    always_ff @(posedge ck) begin
        if (ex_valid) begin
            case (ex_op)
                seq_pkg::OP_MAC:  acc <= acc + product_ext;
                seq_pkg::OP_MACZ: acc <= product_ext;
                default:          acc <= acc;
            endcase
        end
    end

    // SAVE leaves acc untouched, so the next cycle shows every earlier MAC
    always_ff @(posedge ck) begin
        if (rst) begin
            save_valid <= 1'b0;
        end else begin
            save_valid <= ex_valid && (ex_op == seq_pkg::OP_SAVE);
        end
    end

    always_ff @(posedge ck) begin
        save_chan <= ex_chan;
    end

endmodule

`default_nettype wire

// ==== src/seq_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_result (
    input  wire                                ck,
    input  wire                                rst,
    input  wire                                save_valid,
    input  wire [audio_pkg::CHAN_W-1:0]        save_chan,
    input  wire signed [seq_pkg::ACC_W-1:0]    acc,
    input  wire [audio_pkg::CHAN_W-1:0]        result_raddr,
    output logic [15:0]                        result_rdata,
    output logic [15:0]                        left,
    output logic [15:0]                        right,
    output logic [31:0]                        capture
);

    logic signed [seq_pkg::ACC_W-1:0] shifted;
    logic [15:0]                      sat;

    // Q15 gain scaling
    assign shifted = acc >>> 15;

    always_comb begin
        if (shifted > 32767) begin
            sat = 16'h7fff;
        end else if (shifted < -32768) begin
            sat = 16'h8000;
        end else begin
            sat = shifted[15:0];
        end
    end

    dpram #(
        .WIDTH (16),
        .DEPTH (audio_pkg::CHANNELS)
    ) i_result_ram (
        .ck    (ck),
        .we    (save_valid),
        .waddr (save_chan),
        .wdata (sat),
        .raddr (result_raddr),
        .rdata (result_rdata)
    );

    // Even channels feed left, odd ones right
    always_ff @(posedge ck) begin
        if (rst) begin
            left  <= 16'h0;
            right <= 16'h0;
        end else if (save_valid) begin
            if (save_chan[0]) begin
                right <= sat;
            end else begin
                left <= sat;
            end
        end
    end

    // Raw accumulator, before scaling
    always_ff @(posedge ck) begin
        if (save_valid) begin
            capture <= acc[31:0];
        end
    end

endmodule

`default_nettype wire

// ==== src/audio_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_engine (
    input  wire          ck,
    input  wire          rst,
    input  wire          cyc,
    input  wire          we,
    input  wire [31:0]   adr,
    input  wire [31:0]   dat,
    output logic         ack,
    output logic [31:0]  rdt,
    output logic [15:0]  left,
    output logic [15:0]  right,
    output logic         ready
);

    logic                               coef_we;
    logic [audio_pkg::COEF_W-1:0]       coef_waddr;
    logic [audio_pkg::COEF_W-1:0]       coef_raddr;
    logic [31:0]                        coef_rdata;
    logic                               audio_we;
    logic [audio_pkg::AUDIO_W-1:0]      audio_waddr;
    logic [audio_pkg::AUDIO_W-1:0]      audio_raddr;
    logic [15:0]                        audio_rdata;
    logic [audio_pkg::FRAME_W-1:0]      frame;
    logic                               bank;
    logic                               start;
    logic                               done;
    logic                               error;
    logic [31:0]                        capture;
    logic [audio_pkg::CHAN_W-1:0]       result_raddr;
    logic [15:0]                        result_rdata;
    logic                               op_valid;
    seq_pkg::opcode_t                   op;
    logic [audio_pkg::CHAN_W-1:0]       chan;
    logic signed [15:0]                 gain;
    logic signed [seq_pkg::ACC_W-1:0]   acc;
    logic                               save_valid;
    logic [audio_pkg::CHAN_W-1:0]       save_chan;

    assign ready = done;

    host_regs i_host_regs (
        .ck           (ck),
        .rst          (rst),
        .cyc          (cyc),
        .we           (we),
        .adr          (adr),
        .dat          (dat),
        .done         (done),
        .error        (error),
        .capture      (capture),
        .result_rdata (result_rdata),
        .ack          (ack),
        .rdt          (rdt),
        .coef_we      (coef_we),
        .coef_waddr   (coef_waddr),
        .audio_we     (audio_we),
        .audio_waddr  (audio_waddr),
        .frame        (frame),
        .bank         (bank),
        .start        (start),
        .result_raddr (result_raddr)
    );

    // Program memory, both banks
    dpram #(
        .WIDTH (32),
        .DEPTH (audio_pkg::CODE * 2)
    ) i_coef_ram (
        .ck    (ck),
        .we    (coef_we),
        .waddr (coef_waddr),
        .wdata (dat),
        .raddr (coef_raddr),
        .rdata (coef_rdata)
    );

    dpram #(
        .WIDTH (16),
        .DEPTH (audio_pkg::CHANNELS * audio_pkg::FRAMES)
    ) i_audio_ram (
        .ck    (ck),
        .we    (audio_we),
        .waddr (audio_waddr),
        .wdata (dat[15:0]),
        .raddr (audio_raddr),
        .rdata (audio_rdata)
    );

    seq_decode i_seq_decode (
        .ck          (ck),
        .rst         (rst),
        .start       (start),
        .bank        (bank),
        .frame       (frame),
        .coef_rdata  (coef_rdata),
        .coef_raddr  (coef_raddr),
        .audio_raddr (audio_raddr),
        .op_valid    (op_valid),
        .op          (op),
        .chan        (chan),
        .gain        (gain),
        .done        (done),
        .error       (error)
    );

    seq_execute i_seq_execute (
        .ck          (ck),
        .rst         (rst),
        .op_valid    (op_valid),
        .op          (op),
        .chan        (chan),
        .gain        (gain),
        .audio_rdata (audio_rdata),
        .acc         (acc),
        .save_valid  (save_valid),
        .save_chan   (save_chan)
    );

    seq_result i_seq_result (
        .ck           (ck),
        .rst          (rst),
        .save_valid   (save_valid),
        .save_chan    (save_chan),
        .acc          (acc),
        .result_raddr (result_raddr),
        .result_rdata (result_rdata),
        .left         (left),
        .right        (right),
        .capture      (capture)
    );

endmodule

`default_nettype wire

// ==== dv/tb_audio_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_audio_engine;

    logic        ck;
    logic        rst;
    logic        cyc;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic        ack;
    logic [31:0] rdt;
    logic [15:0] left;
    logic [15:0] right;
    logic        ready;

    integer seed;
    int     value_errors;
    int     timeouts;

    // Reference model state
    logic [15:0] audio_mem [2048];
    logic [31:0] prog [2][256];
    logic [31:0] code [$];
    logic [15:0] exp_result [8];
    logic        saved [8];
    logic [15:0] exp_left;
    logic [15:0] exp_right;
    logic [31:0] exp_capture;
    logic        exp_error;
    logic        exp_bank;
    logic [7:0]  frame;

    audio_engine i_audio_engine (
        .ck    (ck),
        .rst   (rst),
        .cyc   (cyc),
        .we    (we),
        .adr   (adr),
        .dat   (dat),
        .ack   (ack),
        .rdt   (rdt),
        .left  (left),
        .right (right),
        .ready (ready)
    );

    initial begin
        ck = 1'b0;
        forever #2 ck = ~ck;
    end

    function automatic logic [31:0] coef_addr(input int i);
        return {audio_pkg::REGION_COEF, 14'h0, i[7:0], 2'b00};
    endfunction

    function automatic logic [31:0] input_addr(input int c, input int f);
        return {audio_pkg::REGION_INPUT, 11'h0, c[2:0], f[7:0], 2'b00};
    endfunction

    function automatic logic [31:0] result_addr(input int c);
        return {audio_pkg::REGION_RESULT, 19'h0, c[2:0], 2'b00};
    endfunction

    function automatic logic [31:0] status_addr(input logic [1:0] idx);
        return {audio_pkg::REGION_STATUS, 20'h0, idx, 2'b00};
    endfunction

    // Arithmetic shift by 15, then clamp to the signed 16-bit range
    function automatic logic [15:0] saturate(input logic signed [39:0] a);
        logic signed [39:0] s;
        s = a >>> 15;
        if (s > 32767) begin
            return 16'h7fff;
        end else if (s < -32768) begin
            return 16'h8000;
        end
        return s[15:0];
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_sample(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        int n;
        @(negedge ck);
        cyc = 1'b1;
        we  = 1'b1;
        adr = a;
        dat = d;
        n   = 0;
        @(negedge ck);
        while (!ack && n < 20) begin
            n++;
            @(negedge ck);
        end
        if (!ack) begin
            $display("Timeout: bus write to 0x%h was never acknowledged", a);
            timeouts++;
        end
        cyc = 1'b0;
        we  = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        int n;
        @(negedge ck);
        cyc = 1'b1;
        we  = 1'b0;
        adr = a;
        n   = 0;
        @(negedge ck);
        while (!ack && n < 20) begin
            n++;
            @(negedge ck);
        end
        if (!ack) begin
            $display("Timeout: bus read from 0x%h was never acknowledged", a);
            timeouts++;
        end
        d   = rdt;
        cyc = 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] s;
        int          n;
        n = 0;
        bus_read(status_addr(audio_pkg::REG_STATUS), s);
        while (s[0] !== 1'b1 && n < 1000) begin
            n++;
            bus_read(status_addr(audio_pkg::REG_STATUS), s);
        end
        if (s[0] !== 1'b1) begin
            $display("Timeout: the sequencer never reported done in the status register");
            timeouts++;
        end
    endtask

    task automatic set_frame(input logic [7:0] f);
        bus_write(status_addr(audio_pkg::REG_CONTROL), {23'h0, f, 1'b0});
        frame = f;
    endtask

    task automatic write_sample(input int c, input int f, input logic [15:0] v);
        bus_write(input_addr(c, f), {16'h0, v});
        audio_mem[{c[2:0], f[7:0]}] = v;
    endtask

    task automatic emit(input logic [3:0] op, input int c, input int off,
                        input logic [15:0] g);
        code.push_back({op, c[2:0], 1'b0, off[7:0], g});
    endtask

    // Host always loads the bank the sequencer is not using
    task automatic load_program();
        for (int i = 0; i < code.size(); i++) begin
            bus_write(coef_addr(i), code[i]);
            prog[!exp_bank][i] = code[i];
        end
        code.delete();
    endtask

    task automatic model_run();
        logic [31:0]        w;
        logic [2:0]         c;
        logic [7:0]         tap;
        logic signed [31:0] prod;
        logic signed [39:0] acc;
        logic               halted;
        int                 pc;
        acc    = '0;
        pc     = 0;
        halted = 1'b0;
        while (!halted && pc < 256) begin
            w    = prog[exp_bank][pc];
            c    = w[27:25];
            // Frame minus offset wraps to 8 bits
            tap  = frame - w[23:16];
            prod = $signed(w[15:0]) * $signed(audio_mem[{c, tap}]);
            case (w[31:28])
                seq_pkg::OP_HALT: halted = 1'b1;
                seq_pkg::OP_MACZ: acc = prod;
                seq_pkg::OP_MAC:  acc = acc + prod;
                seq_pkg::OP_SAVE: begin
                    exp_result[c] = saturate(acc);
                    saved[c]      = 1'b1;
                    exp_capture   = acc[31:0];
                    if (c[0]) begin
                        exp_right = saturate(acc);
                    end else begin
                        exp_left = saturate(acc);
                    end
                end
                default: ;
            endcase
            pc++;
        end
        exp_error = !halted;
    endtask

    task automatic run_program();
        bus_write(status_addr(audio_pkg::REG_EOC), 32'h0);
        exp_bank = !exp_bank;
        model_run();
        wait_done();
    endtask

    task automatic verify_run();
        logic [31:0] d;
        for (int c = 0; c < 8; c++) begin
            if (saved[c]) begin
                bus_read(result_addr(c), d);
                check_word($sformatf("result[%0d]", c), d, {16'h0, exp_result[c]});
            end
        end
        bus_read(status_addr(audio_pkg::REG_CAPTURE), d);
        check_word("capture", d, exp_capture);
        check_sample("left", left, exp_left);
        check_sample("right", right, exp_right);
        bus_read(status_addr(audio_pkg::REG_STATUS), d);
        check_flag("status.done", d[0], 1'b1);
        check_flag("status.error", d[1], exp_error);
        check_flag("status.bank", d[2], exp_bank);
        check_flag("ready", ready, 1'b1);
    endtask

    task automatic test_reset();
        logic [31:0] d;
        bus_read(status_addr(audio_pkg::REG_STATUS), d);
        check_flag("status.done", d[0], 1'b0);
        check_flag("status.error", d[1], 1'b0);
        check_flag("status.bank", d[2], 1'b0);
        check_flag("ready", ready, 1'b0);
        check_sample("left", left, 16'h0);
        check_sample("right", right, 16'h0);
        set_frame(8'h5a);
        bus_read(status_addr(audio_pkg::REG_CONTROL), d);
        check_word("control", d, {23'h0, 8'h5a, 1'b0});
    endtask

    task automatic test_mac_program();
        logic [31:0] r;
        logic [31:0] g;
        set_frame(8'd100);
        for (int c = 0; c < 6; c++) begin
            r = $random(seed);
            g = $random(seed);
            emit(seq_pkg::OP_MACZ, c, r[7:0], g[15:0]);
            r = $random(seed);
            g = $random(seed);
            emit(seq_pkg::OP_MAC, r[10:8], r[7:0], g[15:0]);
            // Unknown opcode must behave as NOP
            emit(4'h9, 0, 0, 16'hffff);
            r = $random(seed);
            g = $random(seed);
            emit(seq_pkg::OP_MAC, r[10:8], r[7:0], g[15:0]);
            emit(seq_pkg::OP_SAVE, c, 0, 16'h0);
        end
        emit(seq_pkg::OP_HALT, 0, 0, 16'h0);
        load_program();
        run_program();
        verify_run();
    endtask

    task automatic test_saturation();
        write_sample(6, 20, 16'h7fff);
        write_sample(7, 20, 16'h8000);
        set_frame(8'd20);
        emit(seq_pkg::OP_MACZ, 6, 0, 16'h7fff);
        emit(seq_pkg::OP_MAC, 6, 0, 16'h7fff);
        emit(seq_pkg::OP_SAVE, 0, 0, 16'h0);
        emit(seq_pkg::OP_MACZ, 7, 0, 16'h7fff);
        emit(seq_pkg::OP_MAC, 7, 0, 16'h7fff);
        emit(seq_pkg::OP_SAVE, 1, 0, 16'h0);
        emit(seq_pkg::OP_HALT, 0, 0, 16'h0);
        load_program();
        run_program();
        verify_run();
        check_sample("left", left, 16'h7fff);
        check_sample("right", right, 16'h8000);
        // Negative gain flips both directions
        emit(seq_pkg::OP_MACZ, 6, 0, 16'h8000);
        emit(seq_pkg::OP_MAC, 6, 0, 16'h8000);
        emit(seq_pkg::OP_SAVE, 2, 0, 16'h0);
        emit(seq_pkg::OP_MACZ, 7, 0, 16'h8000);
        emit(seq_pkg::OP_MAC, 7, 0, 16'h8000);
        emit(seq_pkg::OP_SAVE, 3, 0, 16'h0);
        emit(seq_pkg::OP_HALT, 0, 0, 16'h0);
        load_program();
        run_program();
        verify_run();
        check_sample("left", left, 16'h8000);
        check_sample("right", right, 16'h7fff);
    endtask

    task automatic test_frame_wrap();
        set_frame(8'd3);
        emit(seq_pkg::OP_MACZ, 4, 10, 16'h1234);
        emit(seq_pkg::OP_MAC, 4, 200, 16'hf800);
        emit(seq_pkg::OP_MAC, 5, 255, 16'h2000);
        emit(seq_pkg::OP_SAVE, 4, 0, 16'h0);
        emit(seq_pkg::OP_MACZ, 2, 3, 16'h4000);
        emit(seq_pkg::OP_MAC, 2, 4, 16'h4000);
        emit(seq_pkg::OP_SAVE, 5, 0, 16'h0);
        emit(seq_pkg::OP_HALT, 0, 0, 16'h0);
        load_program();
        run_program();
        verify_run();
    endtask

    task automatic test_bank_swap();
        logic [15:0] first_result [8];
        logic [31:0] first_capture;
        logic [31:0] g;
        logic [31:0] d;
        logic        old_bank;
        old_bank = exp_bank;
        set_frame(8'd50);
        for (int c = 0; c < 8; c++) begin
            g = $random(seed);
            emit(seq_pkg::OP_MACZ, c, c * 3, g[15:0]);
            emit(seq_pkg::OP_MAC, (c + 1) % 8, 200 + c, g[31:16]);
            emit(seq_pkg::OP_SAVE, c, 0, 16'h0);
        end
        emit(seq_pkg::OP_HALT, 0, 0, 16'h0);
        load_program();
        run_program();
        verify_run();
        bus_read(status_addr(audio_pkg::REG_STATUS), d);
        check_flag("status.bank after first swap", d[2], !old_bank);
        first_result  = exp_result;
        first_capture = exp_capture;
        // Second program lands in the bank that just went idle
        emit(seq_pkg::OP_MACZ, 3, 0, 16'h7000);
        emit(seq_pkg::OP_SAVE, 3, 0, 16'h0);
        emit(seq_pkg::OP_HALT, 0, 0, 16'h0);
        load_program();
        run_program();
        verify_run();
        // Rerun the first bank without reloading it
        run_program();
        verify_run();
        for (int c = 0; c < 8; c++) begin
            bus_read(result_addr(c), d);
            check_sample($sformatf("rerun result[%0d]", c), d[15:0], first_result[c]);
        end
        bus_read(status_addr(audio_pkg::REG_CAPTURE), d);
        check_word("rerun capture", d, first_capture);
    endtask

    task automatic test_overrun();
        logic [31:0] d;
        set_frame(8'd7);
        emit(seq_pkg::OP_MACZ, 1, 0, 16'h0100);
        emit(seq_pkg::OP_SAVE, 6, 0, 16'h0);
        for (int i = 2; i < 256; i++) begin
            emit((i % 2) ? 4'h9 : seq_pkg::OP_NOP, 0, 0, 16'h0);
        end
        load_program();
        run_program();
        verify_run();
        bus_read(status_addr(audio_pkg::REG_STATUS), d);
        check_flag("overrun error", d[1], 1'b1);
        emit(seq_pkg::OP_MACZ, 0, 1, 16'h0400);
        emit(seq_pkg::OP_SAVE, 7, 0, 16'h0);
        emit(seq_pkg::OP_HALT, 0, 0, 16'h0);
        load_program();
        run_program();
        verify_run();
    endtask

    initial begin
        logic [31:0] r;
        seed         = 34376;
        value_errors = 0;
        timeouts     = 0;
        rst          = 1'b1;
        cyc          = 1'b0;
        we           = 1'b0;
        adr          = 32'h0;
        dat          = 32'h0;
        exp_left     = 16'h0;
        exp_right    = 16'h0;
        exp_capture  = 32'h0;
        exp_error    = 1'b0;
        exp_bank     = 1'b0;
        frame        = 8'h0;
        for (int c = 0; c < 8; c++) begin
            saved[c] = 1'b0;
        end
        repeat (16) @(negedge ck);
        rst = 1'b0;

        test_reset();
        for (int i = 0; i < 2048; i++) begin
            r = $random(seed);
            write_sample(i / 256, i % 256, r[15:0]);
        end
        test_mac_program();
        test_saturation();
        test_frame_wrap();
        test_bank_swap();
        test_overrun();

        $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/audio_pkg.sv
src/seq_pkg.sv
src/dpram.sv
src/host_regs.sv
src/seq_decode.sv
src/seq_execute.sv
src/seq_result.sv
src/audio_engine.sv
dv/tb_audio_engine.sv
